//--- project.f
hw/l2_pkg.sv
hw/l2_req_router.sv
hw/l2_bank.sv
hw/l2_mem_arbiter.sv
hw/l2_resp_arbiter.sv
hw/l2_cache_multibank.sv
verification/tb_l2_mem_model.sv
verification/tb_l2_cache.sv

//--- verification/tb_l2_cache.sv
`timescale 1ns/100ps
`default_nettype none

module tb_l2_cache
  import l2_pkg::*;
();

  localparam int NUM_SETS   = 16;
  localparam int FIFO_DEPTH = 4;
  localparam int TIMEOUT    = 3000;
  localparam int TX_DEPTH   = 256;
  localparam int NUM_IDS    = 1 << ID_W;

  logic          clk;
  logic          rst_n;
  logic          flush;
  l1_req_t [1:0] l1_req;
  l1_res_t [1:0] l1_res;
  logic    [1:0] credit;
  mem_req_t      mem_req;
  mem_res_t      mem_res;
  logic          mem_ready;
  logic          ready_draw;
  logic    [2:0] delay_draw;
  int            mem_count;

  logic [31:0] stim_lfsr;
  logic [31:0] mem_lfsr;

  // Per-port request queues waiting for a credit
  addr_t   tx_addr [2][TX_DEPTH];
  req_id_t tx_id   [2][TX_DEPTH];
  int      tx_head [2];
  int      tx_tail [2];

  // Outstanding requests keyed by port and id
  logic  exp_valid [2][NUM_IDS];
  addr_t exp_addr  [2][NUM_IDS];

  int   credits [2];
  logic stalled [2];
  int   outstanding;
  int   sent_total;
  int   credit_total;
  int   errors;
  int   tests_run;
  int   tests_failed;

  l2_cache_multibank #(
    .NUM_SETS  (NUM_SETS),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) UUT (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .flush_i    (flush),
    .l1_req_i   (l1_req),
    .mem_res_i  (mem_res),
    .mem_ready_i(mem_ready),
    .l1_res_o   (l1_res),
    .credit_o   (credit),
    .mem_req_o  (mem_req)
  );

  tb_l2_mem_model u_mem (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .mem_req_i   (mem_req),
    .ready_draw_i(ready_draw),
    .delay_draw_i(delay_draw),
    .mem_ready_o (mem_ready),
    .mem_res_o   (mem_res),
    .req_count_o (mem_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ==================================================
  // LFSR with taps 32 22 2 1
  // ==================================================
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] stim_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_step(stim_lfsr);
      r = {r[30:0], stim_lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] mem_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      mem_lfsr = lfsr_step(mem_lfsr);
      r = {r[30:0], mem_lfsr[0]};
    end
    return r;
  endfunction

  // Memory ready and latency draws
  always @(posedge clk) begin
    #1;
    ready_draw = 1'(mem_bits(1));
    delay_draw = 3'(mem_bits(3));
  end

  task automatic report_error(input string msg);
    $display("error at %0d ns: %s", $time, msg);
    errors = errors + 1;
  endtask

  // ==================================================
  // L1 side driver and monitor
  // ==================================================
  // One request per port per cycle while a credit is held
  always @(posedge clk) begin
    #1;
    for (int p = 0; p < 2; p++) begin
      l1_req[p] = '0;
      if (rst_n && tx_head[p] != tx_tail[p]) begin
        if (credits[p] == 0) begin
          stalled[p] = 1'b1;
        end else begin
          if (exp_valid[p][tx_id[p][tx_head[p]]]) begin
            report_error($sformatf("port %0d id %0d reused while outstanding",
                                   p, tx_id[p][tx_head[p]]));
          end
          l1_req[p].valid = 1'b1;
          l1_req[p].addr  = tx_addr[p][tx_head[p]];
          l1_req[p].id    = tx_id[p][tx_head[p]];
          exp_valid[p][tx_id[p][tx_head[p]]] = 1'b1;
          exp_addr[p][tx_id[p][tx_head[p]]]  = tx_addr[p][tx_head[p]];
          credits[p]  = credits[p] - 1;
          sent_total  = sent_total + 1;
          outstanding = outstanding + 1;
          tx_head[p]  = (tx_head[p] + 1) % TX_DEPTH;
        end
      end
    end
  end

  // Outputs sampled mid-cycle where they are stable
  always @(negedge clk) begin
    if (rst_n) begin
      for (int p = 0; p < 2; p++) begin
        if (credit[p]) begin
          credits[p]   = credits[p] + 1;
          credit_total = credit_total + 1;
          if (credits[p] > FIFO_DEPTH) begin
            report_error($sformatf("port %0d holds %0d credits, more than %0d",
                                   p, credits[p], FIFO_DEPTH));
          end
        end
        if (l1_res[p].valid) begin
          if (!exp_valid[p][l1_res[p].id]) begin
            report_error($sformatf("port %0d response id %0d not outstanding",
                                   p, l1_res[p].id));
          end else begin
            // Memory returns the inverted address
            if (l1_res[p].blk !== ~exp_addr[p][l1_res[p].id]) begin
              report_error($sformatf("port %0d id %0d data %h, expected %h", p,
                                     l1_res[p].id, l1_res[p].blk,
                                     ~exp_addr[p][l1_res[p].id]));
            end
            exp_valid[p][l1_res[p].id] = 1'b0;
            outstanding = outstanding - 1;
          end
        end
      end
    end
  end

  task automatic queue_read(input int p, input addr_t a, input req_id_t id);
    tx_addr[p][tx_tail[p]] = a;
    tx_id[p][tx_tail[p]]   = id;
    tx_tail[p] = (tx_tail[p] + 1) % TX_DEPTH;
  endtask

  // Waits until every queued read has been answered
  task automatic wait_drain(input string what);
    int   cycles;
    logic done;
    cycles = 0;
    done = 1'b0;
    while (!done && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles = cycles + 1;
      done = (tx_head[0] == tx_tail[0]) && (tx_head[1] == tx_tail[1]) &&
             (outstanding == 0);
    end
    if (!done) begin
      $display("timeout: %s still had %0d reads open after %0d cycles",
               what, outstanding, TIMEOUT);
      $display("TESTS FAILED");
      $finish;
    end
  endtask

  task automatic pulse_flush();
    @(posedge clk);
    #1 flush = 1'b1;
    @(posedge clk);
    #1 flush = 1'b0;
    @(negedge clk);
  endtask

  task automatic close_test(input string name, input int err_before);
    tests_run = tests_run + 1;
    if (errors > err_before) begin
      tests_failed = tests_failed + 1;
      $display("test %s: failed with %0d errors", name, errors - err_before);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  // ==================================================
  // Directed tests
  // ==================================================
  task automatic reset_quiet();
    int err0;
    err0 = errors;
    repeat (10) begin
      @(negedge clk);
      if (l1_res[0].valid || l1_res[1].valid) begin
        report_error("response valid right after reset");
      end
      if (credit != 2'b00) begin
        report_error($sformatf("credit pulse %b right after reset", credit));
      end
      if (mem_req.valid) begin
        report_error("memory request valid right after reset");
      end
    end
    close_test("reset state", err0);
  endtask

  task automatic miss_then_hit();
    int err0;
    int count0;
    err0 = errors;
    count0 = mem_count;
    queue_read(0, 32'h0000_1230, 4'd3);
    wait_drain("first read");
    if (mem_count != count0 + 1) begin
      report_error($sformatf("miss made %0d memory requests", mem_count - count0));
    end
    // Same line again must hit
    queue_read(0, 32'h0000_1230, 4'd4);
    wait_drain("repeat read");
    if (mem_count != count0 + 1) begin
      report_error("hit reached memory");
    end
    close_test("miss then hit", err0);
  endtask

  task automatic bank_interleave();
    int err0;
    err0 = errors;
    // Different banks in the same cycle
    queue_read(0, 32'h0000_2000, 4'd1);
    queue_read(1, 32'h0000_2004, 4'd9);
    wait_drain("split banks");
    // Same bank from both ports with misses then hits
    queue_read(0, 32'h0000_3008, 4'd2);
    queue_read(1, 32'h0000_3010, 4'd10);
    wait_drain("shared bank misses");
    queue_read(0, 32'h0000_3010, 4'd3);
    queue_read(1, 32'h0000_3008, 4'd11);
    wait_drain("shared bank hits");
    close_test("bank interleave", err0);
  endtask

  task automatic credit_flow();
    int err0;
    int sent0;
    int credit0;
    err0 = errors;
    sent0 = sent_total;
    credit0 = credit_total;
    stalled[0] = 1'b0;
    stalled[1] = 1'b0;
    // All into bank 1 so both FIFOs back up
    for (int i = 0; i < 10; i++) begin
      queue_read(0, 32'h0000_4004 + 32'(i * 8), req_id_t'(i));
      queue_read(1, 32'h0000_5004 + 32'(i * 8), req_id_t'(i));
    end
    wait_drain("credit burst");
    for (int p = 0; p < 2; p++) begin
      if (!stalled[p]) begin
        report_error($sformatf("port %0d never ran out of credits", p));
      end
      if (credits[p] != FIFO_DEPTH) begin
        report_error($sformatf("port %0d ended with %0d credits", p, credits[p]));
      end
    end
    if (credit_total - credit0 != sent_total - sent0) begin
      report_error($sformatf("%0d credits returned for %0d requests",
                             credit_total - credit0, sent_total - sent0));
    end
    close_test("credit flow", err0);
  endtask

  task automatic flush_refetch();
    int err0;
    int count0;
    err0 = errors;
    count0 = mem_count;
    pulse_flush();
    // Line cached in the miss test must be fetched again
    queue_read(0, 32'h0000_1230, 4'd5);
    wait_drain("read after flush");
    if (mem_count != count0 + 1) begin
      report_error($sformatf("read after flush made %0d memory requests",
                             mem_count - count0));
    end
    close_test("flush", err0);
  endtask

  task automatic random_stream();
    addr_t      pool [8];
    req_id_t    next_id [2];
    int         err0;
    int         p;
    logic [2:0] pick;
    err0 = errors;
    next_id[0] = '0;
    next_id[1] = '0;
    for (int i = 0; i < 8; i++) begin
      pool[i] = {30'(stim_bits(30)), 2'b00};
    end
    for (int k = 0; k < 64; k++) begin
      p = int'(stim_bits(1));
      pick = 3'(stim_bits(3));
      queue_read(p, pool[pick], next_id[p]);
      next_id[p] = next_id[p] + 1'b1;
    end
    wait_drain("random stream");
    close_test("random stream", err0);
  endtask

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin
    rst_n = 1'b0;
    flush = 1'b0;
    l1_req = '0;
    ready_draw = 1'b0;
    delay_draw = '0;
    stim_lfsr = 32'd90346;
    mem_lfsr = 32'd90346;
    outstanding = 0;
    sent_total = 0;
    credit_total = 0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    for (int p = 0; p < 2; p++) begin
      tx_head[p] = 0;
      tx_tail[p] = 0;
      credits[p] = FIFO_DEPTH;
      stalled[p] = 1'b0;
      for (int i = 0; i < NUM_IDS; i++) begin
        exp_valid[p][i] = 1'b0;
      end
    end
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);

    reset_quiet();
    miss_then_hit();
    bank_interleave();
    credit_flow();
    flush_refetch();
    random_stream();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/tb_l2_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module tb_l2_mem_model
  import l2_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  mem_req_t   mem_req_i,
  input  logic       ready_draw_i,
  input  logic [2:0] delay_draw_i,
  output logic       mem_ready_o,
  output mem_res_t   mem_res_o,
  output int         req_count_o
);

  // Accepted requests waiting for their answer
  addr_t    pend_addr [$];
  bank_id_t pend_bank [$];
  int       pend_wait [$];

  logic ready_q;
  int   hit_idx;

  initial begin
    mem_ready_o = 1'b0;
    mem_res_o   = '0;
    req_count_o = 0;
    ready_q     = 1'b0;
  end

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      pend_addr.delete();
      pend_bank.delete();
      pend_wait.delete();
      ready_q     = 1'b0;
      req_count_o = 0;
    end else begin
      foreach (pend_wait[i]) begin
        pend_wait[i] = pend_wait[i] - 1;
      end
      // Request taken when ready was high at this edge
      if (mem_req_i.valid && mem_ready_o) begin
        pend_addr.push_back(mem_req_i.addr);
        pend_bank.push_back(mem_req_i.bank);
        pend_wait.push_back(2 + int'(delay_draw_i));
        req_count_o = req_count_o + 1;
      end
      ready_q = ready_draw_i;
    end
    #1;
    // Oldest due entry answers, one fill per cycle
    hit_idx = -1;
    for (int i = 0; i < pend_wait.size(); i++) begin
      if (hit_idx < 0 && pend_wait[i] <= 0) begin
        hit_idx = i;
      end
    end
    mem_res_o = '0;
    if (hit_idx >= 0) begin
      mem_res_o.valid = 1'b1;
      mem_res_o.blk   = ~pend_addr[hit_idx];
      mem_res_o.bank  = pend_bank[hit_idx];
      pend_addr.delete(hit_idx);
      pend_bank.delete(hit_idx);
      pend_wait.delete(hit_idx);
    end
    mem_ready_o = ready_q;
  end

endmodule

`default_nettype wire

//--- hw/l2_cache_multibank.sv
`timescale 1ns/100ps
`default_nettype none

module l2_cache_multibank
  import l2_pkg::*;
#(
  parameter int NUM_SETS   = 16,
  parameter int FIFO_DEPTH = 4
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          flush_i,
  input  l1_req_t [1:0] l1_req_i,
  input  mem_res_t      mem_res_i,
  input  logic          mem_ready_i,
  output l1_res_t [1:0] l1_res_o,
  output logic    [1:0] credit_o,
  output mem_req_t      mem_req_o
);

  // Router to banks
  bank_req_t [1:0] bank_req;
  logic      [1:0] bank_ready;

  // Banks to response arbiter
  bank_res_t [1:0] bank_res;
  logic      [1:0] res_grant;

  // Banks to memory arbiter
  mem_req_t  [1:0] bank_mem_req;
  logic      [1:0] bank_mem_grant;
  mem_res_t  [1:0] bank_fill;

  // ==================================================
  // Request path
  // ==================================================
  l2_req_router #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_router (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .l1_req_i    (l1_req_i),
    .bank_ready_i(bank_ready),
    .bank_req_o  (bank_req),
    .credit_o    (credit_o)
  );

  // Banks interleaved on the bit above the block offset
  for (genvar b = 0; b < 2; b++) begin : gen_bank
    l2_bank #(
      .NUM_SETS(NUM_SETS)
    ) u_bank (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .flush_i    (flush_i),
      .req_i      (bank_req[b]),
      .res_grant_i(res_grant[b]),
      .mem_grant_i(bank_mem_grant[b]),
      .fill_i     (bank_fill[b]),
      .ready_o    (bank_ready[b]),
      .res_o      (bank_res[b]),
      .mem_req_o  (bank_mem_req[b])
    );
  end

  // ==================================================
  // Arbiters
  // ==================================================
  l2_mem_arbiter u_mem_arb (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .bank_mem_req_i  (bank_mem_req),
    .mem_ready_i     (mem_ready_i),
    .mem_res_i       (mem_res_i),
    .bank_mem_grant_o(bank_mem_grant),
    .mem_req_o       (mem_req_o),
    .bank_fill_o     (bank_fill)
  );

  l2_resp_arbiter u_resp_arb (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .bank_res_i (bank_res),
    .res_grant_o(res_grant),
    .l1_res_o   (l1_res_o)
  );

endmodule

`default_nettype wire

//--- hw/l2_resp_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module l2_resp_arbiter
  import l2_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  bank_res_t [1:0] bank_res_i,
  output logic      [1:0] res_grant_o,
  output l1_res_t   [1:0] l1_res_o
);

  // Candidate banks, indexed [port][bank]
  logic [1:0]     cand [2];
  bank_id_t [1:0] sel;
  logic [1:0]     rr_q;

  // ==================================================
  // Per-port merge
  // ==================================================
  always_comb begin
    res_grant_o = '0;
    for (int p = 0; p < 2; p++) begin
      // Banks holding a response for this port
      for (int b = 0; b < 2; b++) begin
        cand[p][b] = bank_res_i[b].valid && (bank_res_i[b].port == port_id_t'(p));
      end
      sel[p] = rr_pick(cand[p], rr_q[p]);

      // Granted response goes out in the same cycle
      l1_res_o[p].valid = |cand[p];
      l1_res_o[p].blk   = bank_res_i[sel[p]].blk;
      l1_res_o[p].id    = bank_res_i[sel[p]].id;

      // A response names one port, so grants never collide
      if (|cand[p]) begin
        res_grant_o[sel[p]] = 1'b1;
      end
    end
  end

  // Advance each port pointer past its winner
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else begin
      for (int p = 0; p < 2; p++) begin
        if (|cand[p]) begin
          rr_q[p] <= ~sel[p];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/l2_mem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module l2_mem_arbiter
  import l2_pkg::*;
(
  input  logic           clk_i,
  input  logic           rst_ni,
  input  mem_req_t [1:0] bank_mem_req_i,
  input  logic           mem_ready_i,
  input  mem_res_t       mem_res_i,
  output logic     [1:0] bank_mem_grant_o,
  output mem_req_t       mem_req_o,
  output mem_res_t [1:0] bank_fill_o
);

  logic [1:0] req_vec;
  bank_id_t   sel;
  bank_id_t   rr_q;
  logic       can_issue;
  logic       issue;
  mem_req_t   mem_req_q;

  // ==================================================
  // Request selection
  // ==================================================
  assign req_vec = {bank_mem_req_i[1].valid, bank_mem_req_i[0].valid};
  assign sel     = rr_pick(req_vec, rr_q);

  // Output slot is free or memory takes it on this edge
  assign can_issue = !mem_req_q.valid || mem_ready_i;
  assign issue     = can_issue && (|req_vec);

  always_comb begin
    bank_mem_grant_o      = '0;
    bank_mem_grant_o[sel] = issue;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      mem_req_q.valid <= 1'b0;
      rr_q            <= '0;
    end else if (issue) begin
      mem_req_q.valid <= 1'b1;
      rr_q            <= ~sel;
    end else if (mem_ready_i) begin
      mem_req_q.valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      mem_req_q.addr <= bank_mem_req_i[sel].addr;
      mem_req_q.bank <= bank_mem_req_i[sel].bank;
    end
  end

  assign mem_req_o = mem_req_q;

  // ==================================================
  // Fill routing
  // ==================================================
  // Only the bank named in the response sees a valid fill
  always_comb begin
    for (int b = 0; b < 2; b++) begin
      bank_fill_o[b].valid = mem_res_i.valid && (mem_res_i.bank == bank_id_t'(b));
      bank_fill_o[b].blk   = mem_res_i.blk;
      bank_fill_o[b].bank  = mem_res_i.bank;
    end
  end

endmodule

`default_nettype wire

//--- hw/l2_bank.sv
`timescale 1ns/100ps
`default_nettype none

module l2_bank
  import l2_pkg::*;
#(
  parameter int NUM_SETS = 16
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      flush_i,
  input  bank_req_t req_i,
  input  logic      res_grant_i,
  input  logic      mem_grant_i,
  input  mem_res_t  fill_i,
  output logic      ready_o,
  output bank_res_t res_o,
  output mem_req_t  mem_req_o
);

  // ==================================================
  // Address split
  // ==================================================
  // Index starts above the bank bit, tag takes the rest
  localparam int IDX_W   = $clog2(NUM_SETS);
  localparam int IDX_LSB = BANK_BIT + 1;
  localparam int TAG_W   = ADDR_W - IDX_LSB - IDX_W;

  typedef logic [IDX_W-1:0] idx_t;
  typedef logic [TAG_W-1:0] tag_t;

  // Line arrays
  logic [NUM_SETS-1:0] valid_q;
  tag_t                tag_q  [NUM_SETS];
  blk_t                data_q [NUM_SETS];

  // Captured request and response data
  bank_state_e state_q;
  addr_t       addr_q;
  req_id_t     id_q;
  port_id_t    port_q;
  blk_t        res_blk_q;

  // Flush seen outside IDLE waits here
  logic        flush_pend_q;

  idx_t        idx;
  tag_t        tag;
  logic        hit;

  assign idx = addr_q[IDX_LSB +: IDX_W];
  assign tag = addr_q[ADDR_W-1 -: TAG_W];
  assign hit = valid_q[idx] && (tag_q[idx] == tag);

  // ==================================================
  // Bank FSM
  // ==================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      valid_q      <= '0;
      flush_pend_q <= 1'b0;
    end else begin
      if (flush_i) begin
        flush_pend_q <= 1'b1;
      end
      unique case (state_q)
        IDLE: begin
          // Invalidate all lines in one cycle
          if (flush_i || flush_pend_q) begin
            valid_q      <= '0;
            flush_pend_q <= 1'b0;
          end
          if (req_i.valid) begin
            state_q <= LOOKUP;
          end
        end
        LOOKUP: begin
          state_q <= hit ? RESPOND : MISS_REQ;
        end
        MISS_REQ: begin
          // Held until the memory arbiter takes it
          if (mem_grant_i) begin
            state_q <= MISS_WAIT;
          end
        end
        MISS_WAIT: begin
          if (fill_i.valid) begin
            valid_q[idx] <= 1'b1;
            state_q      <= RESPOND;
          end
        end
        RESPOND: begin
          if (res_grant_i) begin
            state_q <= IDLE;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // Request capture, array reads and line fill
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req_i.valid) begin
      addr_q <= req_i.addr;
      id_q   <= req_i.id;
      port_q <= req_i.port;
    end
    if (state_q == LOOKUP) begin
      res_blk_q <= data_q[idx];
    end
    // Fill data also answers the request
    if (state_q == MISS_WAIT && fill_i.valid) begin
      tag_q[idx]  <= tag;
      data_q[idx] <= fill_i.blk;
      res_blk_q   <= fill_i.blk;
    end
  end

  // ==================================================
  // Outputs
  // ==================================================
  assign ready_o = (state_q == IDLE);

  assign res_o.valid = (state_q == RESPOND);
  assign res_o.blk   = res_blk_q;
  assign res_o.id    = id_q;
  assign res_o.port  = port_q;

  // Bank index is the interleave bit of the line address
  assign mem_req_o.valid = (state_q == MISS_REQ);
  assign mem_req_o.addr  = addr_q;
  assign mem_req_o.bank  = addr_q[BANK_BIT];

endmodule

`default_nettype wire

//--- hw/l2_req_router.sv
`timescale 1ns/100ps
`default_nettype none

module l2_req_router
  import l2_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  l1_req_t   [1:0] l1_req_i,
  input  logic      [1:0] bank_ready_i,
  output bank_req_t [1:0] bank_req_o,
  output logic      [1:0] credit_o
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  // ==================================================
  // Per-port FIFO storage
  // ==================================================
  addr_t            fifo_addr_q [2][FIFO_DEPTH];
  req_id_t          fifo_id_q   [2][FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q    [2];
  logic [PTR_W-1:0] rd_ptr_q    [2];
  logic [CNT_W-1:0] count_q     [2];

  // Eligible heads, indexed [bank][port]
  logic [1:0]       elig        [2];
  port_id_t [1:0]   sel;
  logic [1:0]       rr_q;
  logic [1:0]       pop;
  logic [1:0]       credit_q;

  // ==================================================
  // Dispatch
  // ==================================================
  always_comb begin
    pop = '0;
    for (int b = 0; b < 2; b++) begin
      // A head is eligible for the bank its address selects
      for (int p = 0; p < 2; p++) begin
        elig[b][p] = (count_q[p] != '0) &&
                     (fifo_addr_q[p][rd_ptr_q[p]][BANK_BIT] == b[0]);
      end
      sel[b] = rr_pick(elig[b], rr_q[b]);
      bank_req_o[b].valid = |elig[b];
      bank_req_o[b].addr  = fifo_addr_q[sel[b]][rd_ptr_q[sel[b]]];
      bank_req_o[b].id    = fifo_id_q[sel[b]][rd_ptr_q[sel[b]]];
      bank_req_o[b].port  = sel[b];
      // Each head maps to one bank, so at most one pop per port
      if (bank_req_o[b].valid && bank_ready_i[b]) begin
        pop[sel[b]] = 1'b1;
      end
    end
  end

  // Pointers, counts, arbitration and credit pulses
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int p = 0; p < 2; p++) begin
        wr_ptr_q[p] <= '0;
        rd_ptr_q[p] <= '0;
        count_q[p]  <= '0;
      end
      rr_q     <= '0;
      credit_q <= '0;
    end else begin
      for (int p = 0; p < 2; p++) begin
        // L1 only sends while holding a credit, push is unconditional
        if (l1_req_i[p].valid) begin
          wr_ptr_q[p] <= (wr_ptr_q[p] == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q[p] + 1'b1;
        end
        if (pop[p]) begin
          rd_ptr_q[p] <= (rd_ptr_q[p] == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q[p] + 1'b1;
        end
        count_q[p] <= count_q[p] + CNT_W'(l1_req_i[p].valid) - CNT_W'(pop[p]);
      end
      // Move past the winner of each bank
      for (int b = 0; b < 2; b++) begin
        if (bank_req_o[b].valid && bank_ready_i[b]) begin
          rr_q[b] <= ~sel[b];
        end
      end
      // One credit per entry leaving a FIFO
      credit_q <= pop;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int p = 0; p < 2; p++) begin
      if (l1_req_i[p].valid) begin
        fifo_addr_q[p][wr_ptr_q[p]] <= l1_req_i[p].addr;
        fifo_id_q[p][wr_ptr_q[p]]   <= l1_req_i[p].id;
      end
    end
  end

  assign credit_o = credit_q;

endmodule

`default_nettype wire

//--- hw/l2_pkg.sv
`default_nettype none

package l2_pkg;

  // ==================================================
  // Widths
  // ==================================================
  localparam int ADDR_W = 32;
  localparam int BLK_W = 32;
  localparam int ID_W = 4;

  // One word per block, bank select sits just above the byte offset
  localparam int BANK_BIT = $clog2(BLK_W / 8);

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [BLK_W-1:0] blk_t;
  typedef logic [ID_W-1:0] req_id_t;
  typedef logic [0:0] port_id_t;
  typedef logic [0:0] bank_id_t;

  // ==================================================
  // Transfer structs
  // ==================================================
  // L1 side
  typedef struct packed {
    logic    valid;
    addr_t   addr;
    req_id_t id;
  } l1_req_t;

  typedef struct packed {
    logic    valid;
    blk_t    blk;
    req_id_t id;
  } l1_res_t;

  // Router to bank, tagged with the source port
  typedef struct packed {
    logic     valid;
    addr_t    addr;
    req_id_t  id;
    port_id_t port;
  } bank_req_t;

  // Bank to response arbiter
  typedef struct packed {
    logic     valid;
    blk_t     blk;
    req_id_t  id;
    port_id_t port;
  } bank_res_t;

  // Memory side, bank index routes the fill back
  typedef struct packed {
    logic     valid;
    addr_t    addr;
    bank_id_t bank;
  } mem_req_t;

  typedef struct packed {
    logic     valid;
    blk_t     blk;
    bank_id_t bank;
  } mem_res_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    MISS_REQ,
    MISS_WAIT,
    RESPOND
  } bank_state_e;

  // Two-way round-robin pick
  // Pointer wins if it requests, else the other one
  function automatic logic rr_pick(input logic [1:0] req, input logic ptr);
    return req[ptr] ? ptr : ~ptr;
  endfunction

endpackage

`default_nettype wire
